//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Minor opcode fields
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // Branch kind, decode to execute
    localparam logic [1:0] BR_NONE   = 2'd0;
    localparam logic [1:0] BR_EQ     = 2'd1;
    localparam logic [1:0] BR_NE     = 2'd2;
    localparam logic [1:0] BR_ALWAYS = 2'd3;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // One instruction word, register form or store/branch form
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } sb;
    } inst_u;

endpackage

`default_nettype wire

//--- design/core_ifu.sv
`timescale 1ns/100ps
`default_nettype none

module core_ifu (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        pc_wen_i,
    input  wire  [core_pkg::XLEN-1:0]  next_pc_i,
    output logic [core_pkg::XLEN-1:0]  imem_addr_o,
    input  wire  [core_pkg::XLEN-1:0]  imem_data_i,
    output logic                       inst_valid_o,
    output logic [core_pkg::XLEN-1:0]  pc_o,
    output core_pkg::inst_u            inst_o
);

    import core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            fetch_pending_q;

    assign imem_addr_o = pc_q;
    assign pc_o        = pc_q;

    // Reset leaves a fetch pending so PC 0 is read right after release
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q            <= '0;
            fetch_pending_q <= 1'b1;
            inst_valid_o    <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            if (pc_wen_i) begin
                pc_q            <= next_pc_i;
                fetch_pending_q <= 1'b1;
            end else if (fetch_pending_q) begin
                fetch_pending_q <= 1'b0;
                inst_valid_o    <= 1'b1;
            end
        end
    end

    // Instruction latch, memory answers in the same cycle
    always_ff @(posedge clk) begin
        if (fetch_pending_q) begin
            inst_o <= imem_data_i;
        end
    end

endmodule

`default_nettype wire

//--- design/core_idu.sv
`timescale 1ns/100ps
`default_nettype none

module core_idu (
    input  wire                              clk,
    input  wire                              reset_i,
    input  wire                              inst_valid_i,
    input  wire  [core_pkg::XLEN-1:0]        pc_i,
    input  wire  core_pkg::inst_u            inst_i,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    input  wire  [core_pkg::XLEN-1:0]        rdata1_i,
    input  wire  [core_pkg::XLEN-1:0]        rdata2_i,
    output logic                             dec_valid_o,
    output logic [core_pkg::XLEN-1:0]        op_a_o,
    output logic [core_pkg::XLEN-1:0]        op_b_o,
    output logic [core_pkg::XLEN-1:0]        store_data_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rd_o,
    output core_pkg::alu_op_e                alu_op_o,
    output core_pkg::wb_sel_e                wb_sel_o,
    output logic                             rf_we_o,
    output logic                             mem_we_o,
    output logic [1:0]                       br_kind_o,
    output logic [core_pkg::XLEN-1:0]        target_o,
    output logic [core_pkg::XLEN-1:0]        pc_o
);

    import core_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            f7_ok;
    logic [XLEN-1:0] op_b;
    alu_op_e         alu_op;
    wb_sel_e         wb_sel;
    logic            rf_we;
    logic            mem_we;
    logic [1:0]      br_kind;
    logic [XLEN-1:0] target;

    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;

    // I and U from the register view, S and B from the store/branch view
    assign imm_i = {{20{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2};
    assign imm_s = {{20{inst_i.sb.imm_hi[6]}}, inst_i.sb.imm_hi, inst_i.sb.imm_lo};
    assign imm_b = {{20{inst_i.sb.imm_hi[6]}}, inst_i.sb.imm_lo[0],
                    inst_i.sb.imm_hi[5:0], inst_i.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {inst_i.r.funct7, inst_i.r.rs2, inst_i.r.rs1, inst_i.r.funct3, 12'b0};
    // J scatters its bits across rs1, funct3, rs2 and funct7
    assign imm_j = {{12{inst_i.r.funct7[6]}}, inst_i.r.rs1, inst_i.r.funct3,
                    inst_i.r.rs2[0], inst_i.r.funct7[5:0], inst_i.r.rs2[4:1], 1'b0};

    assign f7_ok = (inst_i.r.funct7 == F7_BASE) ||
                   (inst_i.r.funct7 == F7_SUB && inst_i.r.funct3 == F3_ADD_SUB);

    // Anything not matched stays a no-op with no write
    always_comb begin
        op_b    = rdata2_i;
        alu_op  = ALU_ADD;
        wb_sel  = WB_ALU;
        rf_we   = 1'b0;
        mem_we  = 1'b0;
        br_kind = BR_NONE;
        target  = pc_i + imm_b;
        case (inst_i.r.opcode)
            OPC_OP: begin
                rf_we = f7_ok;
                case (inst_i.r.funct3)
                    F3_ADD_SUB: alu_op = (inst_i.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    rf_we  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                op_b  = imm_i;
                rf_we = (inst_i.r.funct3 == F3_ADD_SUB);
            end
            OPC_LUI: begin
                op_b   = imm_u;
                alu_op = ALU_PASS_B;
                rf_we  = 1'b1;
            end
            OPC_LOAD: begin
                op_b   = imm_i;
                wb_sel = WB_MEM;
                rf_we  = (inst_i.r.funct3 == F3_WORD);
            end
            OPC_STORE: begin
                op_b   = imm_s;
                mem_we = (inst_i.sb.funct3 == F3_WORD);
            end
            OPC_BRANCH: begin
                if (inst_i.sb.funct3 == F3_BEQ) begin
                    br_kind = BR_EQ;
                end else if (inst_i.sb.funct3 == F3_BNE) begin
                    br_kind = BR_NE;
                end
            end
            OPC_JAL: begin
                br_kind = BR_ALWAYS;
                wb_sel  = WB_PC4;
                rf_we   = 1'b1;
                target  = pc_i + imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            op_a_o       <= rdata1_i;
            op_b_o       <= op_b;
            store_data_o <= rdata2_i;
            rd_o         <= inst_i.r.rd;
            alu_op_o     <= alu_op;
            wb_sel_o     <= wb_sel;
            rf_we_o      <= rf_we;
            mem_we_o     <= mem_we;
            br_kind_o    <= br_kind;
            target_o     <= target;
            pc_o         <= pc_i;
        end
    end

endmodule

`default_nettype wire

//--- design/core_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module core_regfile (
    input  wire                              clk,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  raddr1_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  raddr2_i,
    output logic [core_pkg::XLEN-1:0]        rdata1_o,
    output logic [core_pkg::XLEN-1:0]        rdata2_o,
    input  wire                              we_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  wire  [core_pkg::XLEN-1:0]        wdata_i
);

    import core_pkg::*;

    logic [XLEN-1:0] regs [32];

    // x0 reads as zero whatever the array holds
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- design/core_exu.sv
`timescale 1ns/100ps
`default_nettype none

module core_exu (
    input  wire                              clk,
    input  wire                              reset_i,
    input  wire                              dec_valid_i,
    input  wire  [core_pkg::XLEN-1:0]        op_a_i,
    input  wire  [core_pkg::XLEN-1:0]        op_b_i,
    input  wire  [core_pkg::XLEN-1:0]        store_data_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire  core_pkg::alu_op_e          alu_op_i,
    input  wire  core_pkg::wb_sel_e          wb_sel_i,
    input  wire                              rf_we_i,
    input  wire                              mem_we_i,
    input  wire  [1:0]                       br_kind_i,
    input  wire  [core_pkg::XLEN-1:0]        target_i,
    input  wire  [core_pkg::XLEN-1:0]        pc_i,
    output logic                             exe_valid_o,
    output logic [core_pkg::XLEN-1:0]        result_o,
    output logic [core_pkg::XLEN-1:0]        store_data_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rd_o,
    output core_pkg::wb_sel_e                wb_sel_o,
    output logic                             rf_we_o,
    output logic                             mem_we_o,
    output logic                             taken_o,
    output logic [core_pkg::XLEN-1:0]        target_o,
    output logic [core_pkg::XLEN-1:0]        pc_o
);

    import core_pkg::*;

    logic [XLEN-1:0] alu_res;
    logic            operands_eq;
    logic            taken;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: alu_res = op_a_i + op_b_i;
            ALU_SUB: alu_res = op_a_i - op_b_i;
            ALU_AND: alu_res = op_a_i & op_b_i;
            ALU_OR:  alu_res = op_a_i | op_b_i;
            ALU_XOR: alu_res = op_a_i ^ op_b_i;
            default: alu_res = op_b_i;
        endcase
    end

    // Branches see rs2 data in op_b
    assign operands_eq = (op_a_i == op_b_i);

    always_comb begin
        case (br_kind_i)
            BR_EQ:     taken = operands_eq;
            BR_NE:     taken = !operands_eq;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            result_o     <= alu_res;
            store_data_o <= store_data_i;
            rd_o         <= rd_i;
            wb_sel_o     <= wb_sel_i;
            rf_we_o      <= rf_we_i;
            mem_we_o     <= mem_we_i;
            taken_o      <= taken;
            target_o     <= target_i;
            pc_o         <= pc_i;
        end
    end

endmodule

`default_nettype wire

//--- design/core_wbu.sv
`timescale 1ns/100ps
`default_nettype none

module core_wbu (
    input  wire                              clk,
    input  wire                              reset_i,
    input  wire                              exe_valid_i,
    input  wire  [core_pkg::XLEN-1:0]        result_i,
    input  wire  [core_pkg::XLEN-1:0]        store_data_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire  core_pkg::wb_sel_e          wb_sel_i,
    input  wire                              rf_we_i,
    input  wire                              mem_we_i,
    input  wire                              taken_i,
    input  wire  [core_pkg::XLEN-1:0]        target_i,
    input  wire  [core_pkg::XLEN-1:0]        pc_i,
    output logic [core_pkg::XLEN-1:0]        dmem_addr_o,
    output logic [core_pkg::XLEN-1:0]        dmem_wdata_o,
    output logic                             dmem_we_o,
    input  wire  [core_pkg::XLEN-1:0]        dmem_rdata_i,
    output logic                             rf_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rf_waddr_o,
    output logic [core_pkg::XLEN-1:0]        rf_wdata_o,
    output logic                             pc_wen_o,
    output logic [core_pkg::XLEN-1:0]        next_pc_o,
    output logic                             retire_o,
    output logic [core_pkg::XLEN-1:0]        retire_pc_o
);

    import core_pkg::*;

    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc_i + 32'd4;

    assign dmem_addr_o  = result_i;
    assign dmem_wdata_o = store_data_i;
    assign dmem_we_o    = exe_valid_i && mem_we_i;

    assign rf_we_o    = exe_valid_i && rf_we_i && (rd_i != '0);
    assign rf_waddr_o = rd_i;

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  rf_wdata_o = dmem_rdata_i;
            WB_PC4:  rf_wdata_o = pc_plus4;
            default: rf_wdata_o = result_i;
        endcase
    end

    assign pc_wen_o    = exe_valid_i;
    assign next_pc_o   = taken_i ? target_i : pc_plus4;
    assign retire_o    = exe_valid_i;
    assign retire_pc_o = pc_i;

endmodule

`default_nettype wire

//--- design/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top (
    input  wire                              clk,
    input  wire                              reset_i,
    output wire  [core_pkg::XLEN-1:0]        imem_addr_o,
    input  wire  [core_pkg::XLEN-1:0]        imem_data_i,
    output wire  [core_pkg::XLEN-1:0]        dmem_addr_o,
    output wire  [core_pkg::XLEN-1:0]        dmem_wdata_o,
    output wire                              dmem_we_o,
    input  wire  [core_pkg::XLEN-1:0]        dmem_rdata_i,
    output wire                              retire_o,
    output wire  [core_pkg::XLEN-1:0]        retire_pc_o,
    output wire                              wb_we_o,
    output wire  [core_pkg::REG_ADDR_W-1:0]  wb_addr_o,
    output wire  [core_pkg::XLEN-1:0]        wb_data_o
);

    import core_pkg::*;

    // Fetch to decode
    logic                  if_inst_valid;
    logic [XLEN-1:0]       if_pc;
    inst_u                 if_inst;

    // Register file read side
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;

    // Decode to execute
    logic                  dec_valid;
    logic [XLEN-1:0]       dec_op_a;
    logic [XLEN-1:0]       dec_op_b;
    logic [XLEN-1:0]       dec_store_data;
    logic [REG_ADDR_W-1:0] dec_rd;
    alu_op_e               dec_alu_op;
    wb_sel_e               dec_wb_sel;
    logic                  dec_rf_we;
    logic                  dec_mem_we;
    logic [1:0]            dec_br_kind;
    logic [XLEN-1:0]       dec_target;
    logic [XLEN-1:0]       dec_pc;

    // Execute to write-back
    logic                  exe_valid;
    logic [XLEN-1:0]       exe_result;
    logic [XLEN-1:0]       exe_store_data;
    logic [REG_ADDR_W-1:0] exe_rd;
    wb_sel_e               exe_wb_sel;
    logic                  exe_rf_we;
    logic                  exe_mem_we;
    logic                  exe_taken;
    logic [XLEN-1:0]       exe_target;
    logic [XLEN-1:0]       exe_pc;

    // Write-back back to fetch
    logic                  pc_wen;
    logic [XLEN-1:0]       next_pc;

    core_ifu u_ifu (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_wen_i     (pc_wen),
        .next_pc_i    (next_pc),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .inst_valid_o (if_inst_valid),
        .pc_o         (if_pc),
        .inst_o       (if_inst)
    );

    core_idu u_idu (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (if_inst_valid),
        .pc_i         (if_pc),
        .inst_i       (if_inst),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .dec_valid_o  (dec_valid),
        .op_a_o       (dec_op_a),
        .op_b_o       (dec_op_b),
        .store_data_o (dec_store_data),
        .rd_o         (dec_rd),
        .alu_op_o     (dec_alu_op),
        .wb_sel_o     (dec_wb_sel),
        .rf_we_o      (dec_rf_we),
        .mem_we_o     (dec_mem_we),
        .br_kind_o    (dec_br_kind),
        .target_o     (dec_target),
        .pc_o         (dec_pc)
    );

    // Written from write-back, the same nets feed the debug taps
    core_regfile u_regfile (
        .clk      (clk),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_we_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

    core_exu u_exu (
        .clk          (clk),
        .reset_i      (reset_i),
        .dec_valid_i  (dec_valid),
        .op_a_i       (dec_op_a),
        .op_b_i       (dec_op_b),
        .store_data_i (dec_store_data),
        .rd_i         (dec_rd),
        .alu_op_i     (dec_alu_op),
        .wb_sel_i     (dec_wb_sel),
        .rf_we_i      (dec_rf_we),
        .mem_we_i     (dec_mem_we),
        .br_kind_i    (dec_br_kind),
        .target_i     (dec_target),
        .pc_i         (dec_pc),
        .exe_valid_o  (exe_valid),
        .result_o     (exe_result),
        .store_data_o (exe_store_data),
        .rd_o         (exe_rd),
        .wb_sel_o     (exe_wb_sel),
        .rf_we_o      (exe_rf_we),
        .mem_we_o     (exe_mem_we),
        .taken_o      (exe_taken),
        .target_o     (exe_target),
        .pc_o         (exe_pc)
    );

    core_wbu u_wbu (
        .clk          (clk),
        .reset_i      (reset_i),
        .exe_valid_i  (exe_valid),
        .result_i     (exe_result),
        .store_data_i (exe_store_data),
        .rd_i         (exe_rd),
        .wb_sel_i     (exe_wb_sel),
        .rf_we_i      (exe_rf_we),
        .mem_we_i     (exe_mem_we),
        .taken_i      (exe_taken),
        .target_i     (exe_target),
        .pc_i         (exe_pc),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .rf_we_o      (wb_we_o),
        .rf_waddr_o   (wb_addr_o),
        .rf_wdata_o   (wb_data_o),
        .pc_wen_o     (pc_wen),
        .next_pc_o    (next_pc),
        .retire_o     (retire_o),
        .retire_pc_o  (retire_pc_o)
    );

endmodule

`default_nettype wire

//--- bench/core_ref_model.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// Architectural state of the instruction-set model
logic [31:0] m_regs [32];
logic [31:0] m_dmem [256];
logic [31:0] m_pc;

// What the last stepped instruction should show at retire
logic        exp_rf_we;
logic [4:0]  exp_rf_addr;
logic [31:0] exp_rf_data;
logic        exp_st;
logic [31:0] exp_st_addr;
logic [31:0] exp_st_data;

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        m_dmem[i] = '0;
    end
    m_pc = '0;
endtask

task automatic model_step(input logic [31:0] word);
    inst_u       iw;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        wr;
    iw      = word;
    a       = m_regs[iw.r.rs1];
    b       = m_regs[iw.r.rs2];
    imm_i   = {{20{word[31]}}, word[31:20]};
    imm_s   = {{20{iw.sb.imm_hi[6]}}, iw.sb.imm_hi, iw.sb.imm_lo};
    imm_b   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    next_pc = m_pc + 32'd4;
    wr      = 1'b0;
    res     = '0;
    addr    = '0;
    exp_st  = 1'b0;
    exp_st_addr = '0;
    exp_st_data = '0;
    case (iw.r.opcode)
        OPC_OP: begin
            wr = 1'b1;
            if (iw.r.funct7 == 7'h00 && iw.r.funct3 == 3'b000) begin
                res = a + b;
            end else if (iw.r.funct7 == 7'h20 && iw.r.funct3 == 3'b000) begin
                res = a - b;
            end else if (iw.r.funct7 == 7'h00 && iw.r.funct3 == 3'b100) begin
                res = a ^ b;
            end else if (iw.r.funct7 == 7'h00 && iw.r.funct3 == 3'b110) begin
                res = a | b;
            end else if (iw.r.funct7 == 7'h00 && iw.r.funct3 == 3'b111) begin
                res = a & b;
            end else begin
                wr = 1'b0;
            end
        end
        OPC_OP_IMM: begin
            wr  = (iw.r.funct3 == 3'b000);
            res = a + imm_i;
        end
        OPC_LUI: begin
            wr  = 1'b1;
            res = {word[31:12], 12'b0};
        end
        OPC_LOAD: begin
            addr = a + imm_i;
            wr   = (iw.r.funct3 == 3'b010);
            res  = m_dmem[addr[9:2]];
        end
        OPC_STORE: begin
            if (iw.sb.funct3 == 3'b010) begin
                addr        = a + imm_s;
                exp_st      = 1'b1;
                exp_st_addr = addr;
                exp_st_data = b;
                m_dmem[addr[9:2]] = b;
            end
        end
        OPC_BRANCH: begin
            if ((iw.sb.funct3 == 3'b000 && a == b) || (iw.sb.funct3 == 3'b001 && a != b)) begin
                next_pc = m_pc + imm_b;
            end
        end
        OPC_JAL: begin
            wr      = 1'b1;
            res     = m_pc + 32'd4;
            next_pc = m_pc + imm_j;
        end
        default: ;
    endcase
    // x0 never shows a write
    exp_rf_we   = wr && (iw.r.rd != 5'd0);
    exp_rf_addr = iw.r.rd;
    exp_rf_data = res;
    if (exp_rf_we) begin
        m_regs[iw.r.rd] = res;
    end
    m_pc = next_pc;
endtask

`endif

//--- bench/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;

    import core_pkg::*;

    localparam int          PROG_WORDS      = 64;
    localparam int          NUM_RETIRES     = 300;
    localparam int          RESET_CYCLES    = 8;
    localparam int          WATCHDOG_CYCLES = NUM_RETIRES * 4 + 100;
    localparam logic [31:0] LFSR_SEED       = 32'd89439;

    logic        clk;
    logic        reset_i;
    wire  [31:0] imem_addr_o;
    wire  [31:0] imem_data_i;
    wire  [31:0] dmem_addr_o;
    wire  [31:0] dmem_wdata_o;
    wire         dmem_we_o;
    wire  [31:0] dmem_rdata_i;
    wire         retire_o;
    wire  [31:0] retire_pc_o;
    wire         wb_we_o;
    wire  [4:0]  wb_addr_o;
    wire  [31:0] wb_data_o;

    logic [31:0] imem [PROG_WORDS];
    logic [31:0] dmem [256];
    logic [31:0] lfsr_state;
    int          errors;
    int          retires;
    int          cyc;
    logic        store_pending;
    logic [7:0]  store_idx;
    logic [31:0] store_data;

    `include "core_ref_model.svh"

    // Both memories answer in the same cycle
    assign imem_data_i  = imem[imem_addr_o[7:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

    core_top dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .retire_o     (retire_o),
        .retire_pc_o  (retire_pc_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  base;
        logic [11:0] imm12;
        logic [11:0] mem_off;
        logic [4:0]  hop;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int i = 0; i < PROG_WORDS; i++) begin
            kind    = 4'(rand_bits(4));
            rd      = 5'(rand_bits(3));
            rs1     = 5'(rand_bits(3));
            rs2     = 5'(rand_bits(3));
            imm12   = 12'(rand_bits(12));
            base    = (rand_bits(1) == 32'd1) ? 5'd0 : rs1;
            mem_off = {4'b0000, imm12[5:0], 2'b00};
            hop     = 5'(rand_bits(5));
            // Hops of -8 to +23 words that never land on the branch itself
            if (hop == 5'd8) begin
                hop = 5'd9;
            end
            boff = 13'({hop, 2'b00}) - 13'd32;
            joff = 21'({hop, 2'b00}) - 21'd32;
            if (i < 7) begin
                // Seed x1..x7 first so no unwritten register is read
                imem[i] = enc_i(imm12, 5'd0, 3'b000, 5'(i + 1), OPC_OP_IMM);
            end else begin
                case (kind)
                    4'd0:        imem[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd, OPC_OP);
                    4'd1:        imem[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd, OPC_OP);
                    4'd2:        imem[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd, OPC_OP);
                    4'd3:        imem[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd, OPC_OP);
                    4'd4:        imem[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd, OPC_OP);
                    4'd5, 4'd6:  imem[i] = enc_i(imm12, rs1, 3'b000, rd, OPC_OP_IMM);
                    4'd7:        imem[i] = {imm12, imm12[7:0], rd, OPC_LUI};
                    4'd8, 4'd9:  imem[i] = enc_i(mem_off, base, 3'b010, rd, OPC_LOAD);
                    4'd10, 4'd11: imem[i] = enc_s(mem_off, rs2, base);
                    4'd12:       imem[i] = enc_b(boff, rs2, rs1, 3'b000);
                    4'd13:       imem[i] = enc_b(boff, rs2, rs1, 3'b001);
                    4'd14:       imem[i] = enc_j(joff, rd);
                    default:     imem[i] = {imm12, rs1, 3'b101, rd, 7'b1111111};
                endcase
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED %s at %0t: got %h expected %h", name, $time, got, exp);
    endtask

    // Sampled mid-cycle when every output has settled
    task automatic check_cycle();
        logic exp_retire;
        exp_retire = (cyc % 4 == 3);
        // PC of the instruction in flight until its retire
        if (imem_addr_o !== m_pc) begin
            report_mismatch("imem_addr_o", imem_addr_o, m_pc);
        end
        if (retire_o !== exp_retire) begin
            report_mismatch("retire_o", 32'(retire_o), 32'(exp_retire));
        end
        if (retire_o === 1'b1) begin
            retires++;
            if (retire_pc_o !== m_pc) begin
                report_mismatch("retire_pc_o", retire_pc_o, m_pc);
            end
            model_step(imem[m_pc[7:2]]);
            if (wb_we_o !== exp_rf_we) begin
                report_mismatch("wb_we_o", 32'(wb_we_o), 32'(exp_rf_we));
            end
            if (exp_rf_we && wb_addr_o !== exp_rf_addr) begin
                report_mismatch("wb_addr_o", 32'(wb_addr_o), 32'(exp_rf_addr));
            end
            if (exp_rf_we && wb_data_o !== exp_rf_data) begin
                report_mismatch("wb_data_o", wb_data_o, exp_rf_data);
            end
            if (dmem_we_o !== exp_st) begin
                report_mismatch("dmem_we_o", 32'(dmem_we_o), 32'(exp_st));
            end
            if (exp_st && dmem_addr_o !== exp_st_addr) begin
                report_mismatch("dmem_addr_o", dmem_addr_o, exp_st_addr);
            end
            if (exp_st && dmem_wdata_o !== exp_st_data) begin
                report_mismatch("dmem_wdata_o", dmem_wdata_o, exp_st_data);
            end
            if (dmem_we_o === 1'b1) begin
                store_pending = 1'b1;
                store_idx     = dmem_addr_o[9:2];
                store_data    = dmem_wdata_o;
            end
        end else begin
            if (wb_we_o !== 1'b0) begin
                report_mismatch("wb_we_o", 32'(wb_we_o), 32'd0);
            end
            if (dmem_we_o !== 1'b0) begin
                report_mismatch("dmem_we_o", 32'(dmem_we_o), 32'd0);
            end
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        errors        = 0;
        retires       = 0;
        cyc           = 0;
        store_pending = 1'b0;
        store_idx     = '0;
        store_data    = '0;
        lfsr_state    = LFSR_SEED;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = '0;
        end
        build_program();
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        while (retires < NUM_RETIRES) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            #1;
            // Store lands on the edge that ends the write-back cycle
            if (store_pending) begin
                dmem[store_idx] = store_data;
                store_pending   = 1'b0;
            end
            cyc++;
        end
        $display("Errors: %0d, retires: %0d, cycles: %0d", errors, retires, cyc);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with only %0d retires", WATCHDOG_CYCLES, retires);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
design/core_pkg.sv
design/core_ifu.sv
design/core_idu.sv
design/core_regfile.sv
design/core_exu.sv
design/core_wbu.sv
design/core_top.sv
bench/core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = core_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(shell grep -v '^+' $(FLIST)) bench/core_ref_model.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
